//--- Makefile
LOG = sim.log

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f --top-module decode_tb -Mdir obj_dir -o Vdecode_tb
	./obj_dir/Vdecode_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Checks failed" $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- bench/decode_chk.sv
`timescale 1ns/1ps

module decode_chk (
  input logic                clk,
  input logic                arst_n,
  input logic                instr_valid,
  input rv_decode_pkg::dec_t out_dec,
  input logic                out_valid,
  input logic                trap
);

  // Capture plus dispatch gives a fixed two-cycle latency
  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid == $past(instr_valid, 2))
    else $error("out_valid does not follow instr_valid by two cycles");

  a_trap_valid: assert property (@(posedge clk) disable iff (!arst_n)
    trap |-> out_valid)
    else $error("trap raised without out_valid");

  a_one_pipe: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> $onehot(out_dec.pt))
    else $error("pipe class is not one-hot");

  // Illegal words write nothing
  a_illegal_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && out_dec.pt.illegal) |->
      !(out_dec.rd_en || out_dec.mem_rd_en || out_dec.mem_wr_en))
    else $error("enable set on an illegal word");

endmodule

//--- bench/decode_monitor.sv
`timescale 1ns/1ps

module decode_monitor (
  input logic                clk,
  input logic                arst_n,
  input rv_decode_pkg::dec_t out_dec,
  input logic                out_valid,
  input logic                trap
);

  rv_decode_pkg::dec_t            exp_q[$];
  logic [rv_decode_pkg::xlen-1:0] word_q[$];
  int                             test_idx = 0;
  int                             pass_count = 0;
  int                             error_count = 0;

  task automatic add_expected(input rv_decode_pkg::dec_t exp,
                              input logic [rv_decode_pkg::xlen-1:0] word);
    exp_q.push_back(exp);
    word_q.push_back(word);
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  // Outputs change on the rising edge, sampled on the falling one
  always @(negedge clk) begin
    rv_decode_pkg::dec_t            exp;
    logic [rv_decode_pkg::xlen-1:0] word;
    if (arst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected out_valid at %0d ns with no expected record left", $time);
        error_count++;
      end else begin
        exp  = exp_q.pop_front();
        word = word_q.pop_front();
        test_idx++;
        if (out_dec !== exp || trap !== exp.pt.illegal) begin
          $display("MISMATCH %0d ns: test %0d instr %h expected %h trap %b, got %h trap %b",
                   $time, test_idx, word, exp, exp.pt.illegal, out_dec, trap);
          error_count++;
        end else begin
          $display("PASS test %0d instr %h", test_idx, word);
          pass_count++;
        end
      end
    end
  end

endmodule

//--- bench/decode_stimulus.txt
# instr pc is_c rs1 rs2 rd funct3 funct7 imm pc_target rd_data en pt (all hex)
# en = {rd_en, mem_rd_en, mem_wr_en, use_imm, load_upper}, pt = {alu, mul, lsu, br, illegal}
fff30293 00001000 0 06 1f 05 0 7f ffffffff 00000000 00000000 12 10  addi x5, x6, -1
003100b3 00001004 0 02 03 01 0 00 00000000 00000000 00000000 10 10  add x1, x2, x3
02c58533 00001008 0 0b 0c 0a 0 01 00000000 00000000 00000000 10 08  mul x10, x11, x12
40628233 0000100c 0 05 06 04 0 20 00000000 00000000 00000000 10 10  sub x4, x5, x6
ffc42383 00001010 0 08 1c 07 2 7f fffffffc 00000000 00000000 1a 04  lw x7, -4(x8)
00912a23 00001014 0 02 09 14 2 00 00000014 00000000 00000000 06 04  sw x9, 20(x2)
fe322c23 00001018 0 04 03 18 2 7f fffffff8 00000000 00000000 06 04  sw x3, -8(x4)
123452b7 0000101c 0 08 03 05 5 09 12345000 00000000 12345000 13 10  lui x5, 0x12345
fffff317 00002000 0 1f 1f 06 7 7f fffff000 00000000 00001000 12 10  auipc x6, 0xfffff
001000ef 00003000 0 00 01 01 0 00 00000800 00003800 00003004 12 02  jal x1, +2048
ff1ff06f 00004000 0 1f 11 00 7 7f fffffff0 00003ff0 00004004 12 02  jal x0, -16
fe208ce3 00005000 0 01 02 19 0 7f fffffff8 00004ff8 00000000 00 02  beq x1, x2, -8
00419663 00006000 0 03 04 0c 1 00 0000000c 0000600c 00000000 00 02  bne x3, x4, +12
008280e7 00007000 0 05 08 01 0 00 00000008 00000000 00007004 12 02  jalr x1, 8(x5)
0ff0000f 00007004 0 00 1f 00 0 07 00000000 00000000 00000000 00 10  fence
00000073 00007008 0 00 00 00 0 00 00000000 00000000 00000000 00 10  ecall
00004144 00008000 1 0a 00 09 2 00 00000004 00000000 00000000 1a 04  c.lw x9, 4(x10)
00005c7c 00008002 1 08 00 0f 2 00 0000007c 00000000 00000000 1a 04  c.lw x15, 124(x8)
000012f5 00008004 1 05 00 05 0 00 fffffffd 00000000 00000000 12 10  c.addi x5, -3
0000061d 00008006 1 0c 00 0c 0 00 00000007 00000000 00000000 12 10  c.addi x12, 7
00004505 00008008 1 00 00 00 2 00 00000000 00000000 00000000 00 01  c.li, not supported
0000c000 0000800a 1 00 00 00 6 00 00000000 00000000 00000000 00 01  c.sw, not supported
00a5850b 00009000 0 0b 0a 0a 0 00 00000000 00000000 00000000 00 01  custom-0 opcode
ffffffff 00009004 0 1f 1f 1f 7 7f 00000000 00000000 00000000 00 01  unknown opcode

//--- bench/decode_tb.sv
`timescale 1ns/1ps

module decode_tb;

  logic                           clk;
  logic                           arst_n;
  logic                           instr_valid;
  logic [rv_decode_pkg::xlen-1:0] instr;
  logic [rv_decode_pkg::xlen-1:0] pc;
  rv_decode_pkg::dec_t            out_dec;
  logic                           out_valid;
  logic                           trap;

  logic [rv_decode_pkg::xlen-1:0] instr_q[$];
  logic [rv_decode_pkg::xlen-1:0] pc_q[$];
  rv_decode_pkg::dec_t            exp_q[$];
  int                             n_tests;
  int                             tb_errors;
  logic                           stim_loaded;

  decode_top decode_top_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .out_dec     (out_dec),
    .out_valid   (out_valid),
    .trap        (trap)
  );

  decode_monitor decode_monitor_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .out_dec   (out_dec),
    .out_valid (out_valid),
    .trap      (trap)
  );

  bind decode_top decode_chk decode_chk_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .out_dec     (out_dec),
    .out_valid   (out_valid),
    .trap        (trap)
  );

  always #20 clk = ~clk;

  // Lines that do not scan as hex are comments
  task automatic load_stimulus();
    int                  fd;
    int                  n;
    string               line;
    logic [31:0]         f_instr, f_pc, f_imm, f_target, f_rd_data;
    logic [7:0]          f_isc, f_rs1, f_rs2, f_rd, f_f3, f_f7, f_en, f_pt;
    rv_decode_pkg::dec_t rec;
    fd = $fopen("bench/decode_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file bench/decode_stimulus.txt");
      tb_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f_instr, f_pc, f_isc,
                    f_rs1, f_rs2, f_rd, f_f3, f_f7, f_imm, f_target, f_rd_data, f_en, f_pt);
        if (n == 13) begin
          rec               = '0;
          rec.is_compressed = f_isc[0];
          rec.rs1_addr      = f_rs1[4:0];
          rec.rs2_addr      = f_rs2[4:0];
          rec.rd_addr       = f_rd[4:0];
          rec.imm           = f_imm;
          rec.pc_target     = f_target;
          rec.rd_data       = f_rd_data;
          rec.rd_en         = f_en[4];
          rec.mem_rd_en     = f_en[3];
          rec.mem_wr_en     = f_en[2];
          rec.use_imm       = f_en[1];
          rec.load_upper    = f_en[0];
          rec.funct3        = f_f3[2:0];
          rec.funct7        = f_f7[6:0];
          rec.pt            = rv_decode_pkg::pipeline_t'(f_pt[4:0]);
          instr_q.push_back(f_instr);
          pc_q.push_back(f_pc);
          exp_q.push_back(rec);
        end else if (n > 0) begin
          $display("Malformed stimulus line: %s", line);
          tb_errors++;
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    int gap;
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    n_tests     = 0;
    tb_errors   = 0;
    stim_loaded = 1'b0;
    void'($urandom(92147));
    load_stimulus();
    n_tests     = exp_q.size();
    stim_loaded = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    arst_n = 1'b1;
    foreach (exp_q[i]) begin
      @(posedge clk);
      #2;
      instr_valid = 1'b1;
      instr       = instr_q[i];
      pc          = pc_q[i];
      decode_monitor_i.add_expected(exp_q[i], instr_q[i]);
      gap = $urandom % 3;  // Zero gap gives back-to-back strobes
      repeat (gap) begin
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
      end
    end
    @(posedge clk);
    #2;
    instr_valid = 1'b0;
    while (decode_monitor_i.pending() != 0) @(posedge clk);
    repeat (4) @(posedge clk);  // Room for any stray out_valid
    $display("Tests %0d, passed %0d, errors %0d", n_tests, decode_monitor_i.pass_count,
             decode_monitor_i.error_count + tb_errors);
    if (tb_errors == 0 && decode_monitor_i.error_count == 0 && n_tests > 0 &&
        decode_monitor_i.pass_count == n_tests) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Four cycles per test covers the largest gap plus latency
  initial begin
    wait (stim_loaded);
    repeat (n_tests * 4 + 50) @(posedge clk);
    $display("Timeout after %0d cycles, %0d expected records never arrived",
             n_tests * 4 + 50, decode_monitor_i.pending());
    $display("Checks failed");
    $finish;
  end

endmodule

//--- common/rv_decode_pkg.sv
package rv_decode_pkg;

  localparam int xlen       = 32;  // Data and address width
  localparam int reg_addr_w = 5;   // Register index width

  // Major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    LOAD    = 5'b00000,
    MISCMEM = 5'b00011,
    AUIPC   = 5'b00101,
    OPIMM32 = 5'b00100,
    STORE   = 5'b01000,
    LUI     = 5'b01101,
    OP32    = 5'b01100,
    BRANCH  = 5'b11000,
    JALR    = 5'b11001,
    JAL     = 5'b11011,
    SYSTEM  = 5'b11100
  } opc_t;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J,
    IMM_CL,   // C.LW word offset
    IMM_CI,   // C.ADDI signed 6-bit
    IMM_NONE
  } imm_fmt_t;

  // One-hot execution pipe
  typedef struct packed {
    logic alu;
    logic mul;
    logic lsu;
    logic br;
    logic illegal;
  } pipeline_t;

  typedef struct packed {
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
  } fetch_t;

  typedef struct packed {
    logic                  is_compressed;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [reg_addr_w-1:0] rd_addr;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       pc_target;
    logic [xlen-1:0]       rd_data;   // Link or upper-immediate result
    logic                  rd_en;
    logic                  mem_rd_en;
    logic                  mem_wr_en;
    logic                  use_imm;
    logic                  load_upper;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    pipeline_t             pt;
  } dec_t;

endpackage

//--- decoder/decoder.sv
`timescale 1ns/1ps

module decoder (
  input  rv_decode_pkg::fetch_t fetch,
  input  logic                  fetch_valid,
  output rv_decode_pkg::dec_t   dec,
  output logic                  dec_valid
);

  rv_decode_pkg::opc_t               opc;
  rv_decode_pkg::imm_fmt_t           imm_type;
  logic [rv_decode_pkg::xlen-1:0]    imm;
  logic [rv_decode_pkg::xlen-1:0]    target_sum;
  logic [rv_decode_pkg::xlen-1:0]    link_sum;
  logic                              is_compressed;
  logic                              sel_lui;
  logic                              sel_auipc;
  logic                              sel_link;
  logic                              sel_target;

  assign opc           = rv_decode_pkg::opc_t'(fetch.instr[6:2]);
  assign is_compressed = fetch.instr[1:0] != 2'b11;

  // Result selects only apply to full-length words
  assign sel_lui    = !is_compressed && opc == rv_decode_pkg::LUI;
  assign sel_auipc  = !is_compressed && opc == rv_decode_pkg::AUIPC;
  assign sel_link   = !is_compressed &&
                      (opc == rv_decode_pkg::JAL || opc == rv_decode_pkg::JALR);
  assign sel_target = !is_compressed &&
                      (opc == rv_decode_pkg::JAL || opc == rv_decode_pkg::BRANCH);

  assign target_sum = fetch.pc + imm;
  assign link_sum   = fetch.pc + 32'd4;  // No compressed jumps in the subset

  always_comb begin
    dec               = '0;
    imm_type          = rv_decode_pkg::IMM_NONE;
    dec.is_compressed = is_compressed;

    if (is_compressed) begin
      // C.LW and C.ADDI funct3 already match LW and ADD
      dec.funct3 = fetch.instr[15:13];
      case ({fetch.instr[1:0], fetch.instr[15:13]})
        5'b00_010: begin  // C.LW, 3-bit regs map to x8..x15
          dec.rd_addr   = {2'b01, fetch.instr[4:2]};
          dec.rs1_addr  = {2'b01, fetch.instr[9:7]};
          imm_type      = rv_decode_pkg::IMM_CL;
          dec.rd_en     = 1'b1;
          dec.mem_rd_en = 1'b1;
          dec.use_imm   = 1'b1;
          dec.pt.lsu    = 1'b1;
        end
        5'b01_000: begin  // C.ADDI
          dec.rd_addr  = fetch.instr[11:7];
          dec.rs1_addr = fetch.instr[11:7];
          imm_type     = rv_decode_pkg::IMM_CI;
          dec.rd_en    = 1'b1;
          dec.use_imm  = 1'b1;
          dec.pt.alu   = 1'b1;
        end
        default: dec.pt.illegal = 1'b1;
      endcase
    end else begin
      dec.rd_addr  = fetch.instr[11:7];
      dec.rs1_addr = fetch.instr[19:15];
      dec.rs2_addr = fetch.instr[24:20];
      dec.funct3   = fetch.instr[14:12];
      dec.funct7   = fetch.instr[31:25];
      case (opc)
        rv_decode_pkg::LOAD: begin
          imm_type      = rv_decode_pkg::IMM_I;
          dec.rd_en     = 1'b1;
          dec.mem_rd_en = 1'b1;
          dec.use_imm   = 1'b1;
          dec.pt.lsu    = 1'b1;
        end
        rv_decode_pkg::STORE: begin
          imm_type      = rv_decode_pkg::IMM_S;
          dec.mem_wr_en = 1'b1;
          dec.use_imm   = 1'b1;
          dec.pt.lsu    = 1'b1;
        end
        rv_decode_pkg::OPIMM32: begin
          imm_type    = rv_decode_pkg::IMM_I;
          dec.rd_en   = 1'b1;
          dec.use_imm = 1'b1;
          dec.pt.alu  = 1'b1;
        end
        rv_decode_pkg::OP32: begin
          dec.rd_en = 1'b1;
          if (fetch.instr[31:25] == 7'b0000001) dec.pt.mul = 1'b1;  // M extension
          else dec.pt.alu = 1'b1;
        end
        rv_decode_pkg::LUI, rv_decode_pkg::AUIPC: begin
          imm_type       = rv_decode_pkg::IMM_U;
          dec.rd_en      = 1'b1;
          dec.use_imm    = 1'b1;
          dec.load_upper = opc == rv_decode_pkg::LUI;
          dec.pt.alu     = 1'b1;
        end
        rv_decode_pkg::BRANCH: begin
          imm_type  = rv_decode_pkg::IMM_B;
          dec.pt.br = 1'b1;
        end
        rv_decode_pkg::JAL: begin
          imm_type    = rv_decode_pkg::IMM_J;
          dec.rd_en   = 1'b1;
          dec.use_imm = 1'b1;
          dec.pt.br   = 1'b1;
        end
        rv_decode_pkg::JALR: begin  // Target needs rs1, resolved later
          imm_type    = rv_decode_pkg::IMM_I;
          dec.rd_en   = 1'b1;
          dec.use_imm = 1'b1;
          dec.pt.br   = 1'b1;
        end
        rv_decode_pkg::MISCMEM: dec.pt.alu = 1'b1;  // Fence acts as a no-op
        rv_decode_pkg::SYSTEM: begin
          imm_type   = rv_decode_pkg::IMM_I;
          dec.pt.alu = 1'b1;
        end
        default: dec.pt.illegal = 1'b1;
      endcase
    end

    dec.imm = imm;
    if (sel_target) dec.pc_target = target_sum;
    if (sel_lui) dec.rd_data = imm;
    else if (sel_auipc) dec.rd_data = target_sum;
    else if (sel_link) dec.rd_data = link_sum;
  end

  assign dec_valid = fetch_valid;

  sign_extend_imm sign_extend_imm_i (
    .instr    (fetch.instr),
    .imm_type (imm_type),
    .imm_out  (imm)
  );

endmodule

//--- decoder/sign_extend_imm.sv
`timescale 1ns/1ps

module sign_extend_imm (
  input  logic [rv_decode_pkg::xlen-1:0] instr,
  input  rv_decode_pkg::imm_fmt_t        imm_type,
  output logic [rv_decode_pkg::xlen-1:0] imm_out
);

  always_comb begin
    case (imm_type)
      rv_decode_pkg::IMM_I: begin
        imm_out = {{20{instr[31]}}, instr[31:20]};
      end
      rv_decode_pkg::IMM_S: begin
        imm_out = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      rv_decode_pkg::IMM_B: begin  // Halfword aligned offset
        imm_out = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                   instr[11:8], 1'b0};
      end
      rv_decode_pkg::IMM_U: begin
        imm_out = {instr[31:12], 12'b0};
      end
      rv_decode_pkg::IMM_J: begin
        imm_out = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                   instr[30:21], 1'b0};
      end
      rv_decode_pkg::IMM_CL: begin  // uimm[6|5:3|2], scaled by 4
        imm_out = {25'b0, instr[5], instr[12:10], instr[6], 2'b00};
      end
      rv_decode_pkg::IMM_CI: begin  // Sign bit sits in instr[12]
        imm_out = {{26{instr[12]}}, instr[12], instr[6:2]};
      end
      default: begin
        imm_out = '0;
      end
    endcase
  end

endmodule

//--- logic/decode_top.sv
`timescale 1ns/1ps

module decode_top (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           instr_valid,
  input  logic [rv_decode_pkg::xlen-1:0] instr,
  input  logic [rv_decode_pkg::xlen-1:0] pc,
  output rv_decode_pkg::dec_t            out_dec,
  output logic                           out_valid,
  output logic                           trap
);

  rv_decode_pkg::fetch_t fetch;
  rv_decode_pkg::dec_t   dec;
  logic                  fetch_valid;
  logic                  dec_valid;

  // Stage 1, latch the incoming word
  instr_capture instr_capture_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .fetch       (fetch),
    .fetch_valid (fetch_valid)
  );

  decoder decoder_i (
    .fetch       (fetch),
    .fetch_valid (fetch_valid),
    .dec         (dec),
    .dec_valid   (dec_valid)
  );

  // Stage 2, present the bundle
  dispatch_reg dispatch_reg_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .dec       (dec),
    .dec_valid (dec_valid),
    .out_dec   (out_dec),
    .out_valid (out_valid),
    .trap      (trap)
  );

endmodule

//--- logic/dispatch_reg.sv
`timescale 1ns/1ps

module dispatch_reg (
  input  logic                clk,
  input  logic                arst_n,
  input  rv_decode_pkg::dec_t dec,
  input  logic                dec_valid,
  output rv_decode_pkg::dec_t out_dec,
  output logic                out_valid,
  output logic                trap
);

  rv_decode_pkg::dec_t masked;

  // Illegal words must not write anything downstream
  always_comb begin
    masked = dec;
    if (dec.pt.illegal) begin
      masked.rd_en     = 1'b0;
      masked.mem_rd_en = 1'b0;
      masked.mem_wr_en = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      out_dec <= masked;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      trap      <= 1'b0;
    end else begin
      out_valid <= dec_valid;
      trap      <= dec_valid && dec.pt.illegal;  // Pulses together with out_valid
    end
  end

endmodule

//--- logic/instr_capture.sv
`timescale 1ns/1ps

module instr_capture (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        instr_valid,
  input  logic [rv_decode_pkg::xlen-1:0] instr,
  input  logic [rv_decode_pkg::xlen-1:0] pc,
  output rv_decode_pkg::fetch_t       fetch,
  output logic                        fetch_valid
);

  // Word and pc are only loaded on the strobe
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      fetch.instr <= instr;
      fetch.pc    <= pc;
    end
  end

  // Valid follows the strobe by one cycle, back-to-back allowed
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= instr_valid;
    end
  end

endmodule

//--- project.f
common/rv_decode_pkg.sv
logic/instr_capture.sv
decoder/sign_extend_imm.sv
decoder/decoder.sv
logic/dispatch_reg.sv
logic/decode_top.sv
bench/decode_chk.sv
bench/decode_monitor.sv
bench/decode_tb.sv
